//--- zc_pkg.sv
/*
 * Shared widths, encodings and helpers for the Zcmp push/pop sequencer
 * Register lists below 4 are reserved and map to zero saved registers
 */

package zc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic [15:0] cinstr_t;
  typedef logic [31:0] instr_word_t;
  typedef logic [3:0]  rlist_t;
  typedef logic [3:0]  seq_cnt_t;
  // Same width as the load/store immediate
  typedef logic [11:0] stack_adj_t;
  typedef logic [4:0]  reg_num_t;

  // Decoded instruction kind
  typedef enum logic [2:0] {
    NONE,
    PUSH,
    POP,
    POPRET,
    POPRETZ,
    MVA01S,
    MVSA01
  } seq_kind_e;

  // Sequencer FSM states
  typedef enum logic [2:0] {
    S_IDLE,
    S_PUSH,
    S_POP,
    S_DMOVE,
    S_RA,
    S_SP,
    S_A0,
    S_RET
  } seq_state_e;

  //////////////////////////////////////////////////////////////////////
  // Register numbers and opcodes
  //////////////////////////////////////////////////////////////////////

  localparam reg_num_t REG_RA = 5'd1;
  localparam reg_num_t REG_SP = 5'd2;
  localparam reg_num_t REG_A0 = 5'd10;
  localparam reg_num_t REG_A1 = 5'd11;

  localparam logic [6:0] OPCODE_LOAD  = 7'h03;
  localparam logic [6:0] OPCODE_STORE = 7'h23;
  localparam logic [6:0] OPCODE_OPIMM = 7'h13;
  localparam logic [6:0] OPCODE_JALR  = 7'h67;

  // Number of s-registers named by a register list
  function automatic seq_cnt_t reg_count(rlist_t rlist);
    seq_cnt_t n;
    if (rlist == 4'd15) begin
      // s10 is never saved alone, so 15 covers s0 to s11
      n = 4'd12;
    end else if (rlist < 4'd4) begin
      n = 4'd0;
    end else begin
      n = rlist - 4'd4;
    end
    return n;
  endfunction

  // Bytes for the s-registers plus ra, aligned up to 16
  function automatic stack_adj_t stack_adj_base(rlist_t rlist);
    stack_adj_t bytes;
    bytes = (stack_adj_t'(reg_count(rlist)) + 12'd1) << 2;
    return (bytes + 12'd15) & 12'hff0;
  endfunction

  // s0/s1 are x8/x9, s2 to s11 are x18 to x27
  function automatic reg_num_t sreg_to_regnum(seq_cnt_t idx);
    reg_num_t rn;
    if (idx < 4'd2) begin
      rn = 5'd8 + reg_num_t'(idx);
    end else begin
      rn = 5'd16 + reg_num_t'(idx);
    end
    return rn;
  endfunction

endpackage

//--- zc_decode.sv
/*
 * Classifies a 16-bit word as one of the sequenced Zcmp instructions
 * Kind is reported even when illegal, legal_o qualifies it
 * With RV32E set only s0 and s1 may be named
 */

`timescale 1ns/1ps

module zc_decode import zc_pkg::*; #(
  parameter bit RV32E = 1'b0
) (
  input  cinstr_t   instr_i,
  output seq_kind_e seq_kind_o,
  output logic      legal_o
);

  rlist_t     rlist;
  logic [2:0] mv_r1;
  logic [2:0] mv_r2;
  logic       grp_sel;
  logic       rlist_ok;
  logic       move_ok;

  assign rlist = instr_i[7:4];
  // s-register fields of the double moves
  assign mv_r1 = instr_i[9:7];
  assign mv_r2 = instr_i[4:2];

  // Quadrant 2 with funct3 101 holds the whole group
  assign grp_sel = (instr_i[1:0] == 2'b10) && (instr_i[15:13] == 3'b101);

  //////////////////////////////////////////////////////////////////////
  // Kind decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    seq_kind_o = NONE;
    if (grp_sel) begin
      case (instr_i[12:8])
        5'b11000: seq_kind_o = PUSH;
        5'b11010: seq_kind_o = POP;
        5'b11100: seq_kind_o = POPRETZ;
        5'b11110: seq_kind_o = POPRET;
        default: begin
          // Double moves share 12:10 and differ in 6:5
          if (instr_i[12:10] == 3'b011) begin
            if (instr_i[6:5] == 2'b11) begin
              seq_kind_o = MVA01S;
            end else if (instr_i[6:5] == 2'b01) begin
              seq_kind_o = MVSA01;
            end
          end
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Legality
  //////////////////////////////////////////////////////////////////////

  // Lists 0 to 3 are reserved
  // RV32E stops at s1, which is list value 6
  assign rlist_ok = (rlist > 4'd3) && (!RV32E || (rlist < 4'd7));

  // Both moves must name two different s-registers
  assign move_ok = (mv_r1 != mv_r2) &&
                   (!RV32E || ((mv_r1 < 3'd2) && (mv_r2 < 3'd2)));

  always_comb begin
    case (seq_kind_o)
      PUSH, POP, POPRET, POPRETZ: legal_o = rlist_ok;
      MVA01S, MVSA01:             legal_o = move_ok;
      default:                    legal_o = 1'b0;
    endcase
  end

endmodule

//--- zc_stack_calc.sv
/*
 * Stack arithmetic for push/pop sequences, driven by the beat counter
 * Offsets are byte offsets from sp as used by lw/sw
 */

`timescale 1ns/1ps

module zc_stack_calc import zc_pkg::*; (
  input  rlist_t     rlist_i,
  input  logic [1:0] spimm_i,
  input  seq_kind_e  seq_kind_i,
  input  seq_cnt_t   cnt_i,
  output seq_cnt_t   regs_saved_o,
  output stack_adj_t total_adj_o,
  output stack_adj_t cur_adj_o,
  output seq_cnt_t   sreg_idx_o
);

  stack_adj_t base_adj;
  stack_adj_t step;

  assign regs_saved_o = reg_count(rlist_i);
  assign base_adj     = stack_adj_base(rlist_i);

  // Extra frame space comes in 16 byte units
  assign total_adj_o = base_adj + {6'b0, spimm_i, 4'b0000};

  // Distance of the current slot below the frame top
  assign step = (stack_adj_t'(cnt_i) + 12'd1) << 2;

  always_comb begin
    case (seq_kind_i)
      // Stores go below the old sp starting at -4
      PUSH: cur_adj_o = -step;
      // Loads start from the top of the frame, which sp still points below
      POP, POPRET, POPRETZ: cur_adj_o = total_adj_o - step;
      default: cur_adj_o = '0;
    endcase
  end

  // Highest s-register first
  assign sreg_idx_o = regs_saved_o - cnt_i - 4'd1;

endmodule

//--- zc_seq_fsm.sv
/*
 * Sequence FSM with beat counter and handshake generation
 * State and count only move on an accepted beat
 * Any cycle without a valid output returns the FSM to S_IDLE
 */

`timescale 1ns/1ps

module zc_seq_fsm import zc_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       valid_i,
  input  logic       ready_i,
  input  logic       kill_i,
  input  logic       legal_i,
  input  seq_kind_e  seq_kind_i,
  input  seq_cnt_t   regs_saved_i,
  output seq_state_e state_o,
  output seq_cnt_t   cnt_o,
  output logic       valid_o,
  output logic       ready_o,
  output logic       seq_first_o,
  output logic       seq_last_o
);

  seq_state_e state_q;
  seq_state_e state_d;
  seq_cnt_t   cnt_q;
  logic       last;

  // Kill also forces valid low, which makes the sequencer ready
  assign valid_o = legal_i && valid_i && !kill_i;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    last    = 1'b0;
    case (state_q)
      S_IDLE: begin
        case (seq_kind_i)
          PUSH, POP, POPRET, POPRETZ: begin
            if (regs_saved_i == 4'd0) begin
              // ra went out first, sp adjust next
              state_d = S_SP;
            end else if (regs_saved_i == 4'd1) begin
              state_d = S_RA;
            end else if (seq_kind_i == PUSH) begin
              state_d = S_PUSH;
            end else begin
              state_d = S_POP;
            end
          end
          MVA01S, MVSA01: state_d = S_DMOVE;
          default:        state_d = S_IDLE;
        endcase
      end
      S_PUSH, S_POP: begin
        // Lowest s-register reached
        if (cnt_q == regs_saved_i - 4'd1) begin
          state_d = S_RA;
        end
      end
      S_RA: state_d = S_SP;
      S_SP: begin
        if (seq_kind_i == POPRETZ) begin
          state_d = S_A0;
        end else if (seq_kind_i == POPRET) begin
          state_d = S_RET;
        end else begin
          state_d = S_IDLE;
          last    = 1'b1;
        end
      end
      S_A0: state_d = S_RET;
      S_DMOVE, S_RET: begin
        state_d = S_IDLE;
        last    = 1'b1;
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end else if (!valid_o) begin
      // Abandon any partial sequence
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end else if (ready_i) begin
      state_q <= state_d;
      cnt_q   <= last ? 4'd0 : cnt_q + 4'd1;
    end
  end

  // Fetch side takes the next word once the last beat is accepted
  assign ready_o     = !valid_o || (last && ready_i);
  assign seq_first_o = valid_o && (state_q == S_IDLE);
  assign seq_last_o  = valid_o && last;

  assign state_o = state_q;
  assign cnt_o   = cnt_q;

endmodule

//--- zc_instr_gen.sv
/*
 * Encodes the 32-bit base instruction for the current sequence step
 * Non-sequenced words are passed through zero extended
 */

`timescale 1ns/1ps

module zc_instr_gen import zc_pkg::*; (
  input  cinstr_t     instr_i,
  input  seq_state_e  state_i,
  input  seq_kind_e   seq_kind_i,
  input  seq_cnt_t    regs_saved_i,
  input  stack_adj_t  cur_adj_i,
  input  stack_adj_t  total_adj_i,
  input  seq_cnt_t    sreg_idx_i,
  output instr_word_t instr_o
);

  //////////////////////////////////////////////////////////////////////
  // Encoders
  //////////////////////////////////////////////////////////////////////

  // lw rd, off(sp)
  function automatic instr_word_t enc_lw(reg_num_t rd, stack_adj_t off);
    return {off, REG_SP, 3'b010, rd, OPCODE_LOAD};
  endfunction

  // sw rs2, off(sp)
  function automatic instr_word_t enc_sw(reg_num_t rs2, stack_adj_t off);
    return {off[11:5], rs2, REG_SP, 3'b010, off[4:0], OPCODE_STORE};
  endfunction

  // addi rd, rs1, imm
  function automatic instr_word_t enc_addi(reg_num_t rd, reg_num_t rs1, stack_adj_t imm);
    return {imm, rs1, 3'b000, rd, OPCODE_OPIMM};
  endfunction

  logic       is_load;
  reg_num_t   sreg_rn;
  reg_num_t   mv_rn1;
  reg_num_t   mv_rn2;
  stack_adj_t sp_imm;

  assign is_load = seq_kind_i inside {POP, POPRET, POPRETZ};
  assign sreg_rn = sreg_to_regnum(sreg_idx_i);
  assign mv_rn1  = sreg_to_regnum(seq_cnt_t'(instr_i[9:7]));
  assign mv_rn2  = sreg_to_regnum(seq_cnt_t'(instr_i[4:2]));

  // Pop releases the frame, push allocates it
  assign sp_imm = is_load ? total_adj_i : -total_adj_i;

  always_comb begin
    instr_o = {16'h0000, instr_i};
    case (state_i)
      S_IDLE: begin
        // First beat, start with ra if no s-registers are saved
        case (seq_kind_i)
          PUSH: begin
            instr_o = (regs_saved_i == 4'd0) ? enc_sw(REG_RA, cur_adj_i)
                                             : enc_sw(sreg_rn, cur_adj_i);
          end
          POP, POPRET, POPRETZ: begin
            instr_o = (regs_saved_i == 4'd0) ? enc_lw(REG_RA, cur_adj_i)
                                             : enc_lw(sreg_rn, cur_adj_i);
          end
          MVSA01:  instr_o = enc_addi(mv_rn1, REG_A0, 12'h000);
          MVA01S:  instr_o = enc_addi(REG_A0, mv_rn1, 12'h000);
          default: instr_o = {16'h0000, instr_i};
        endcase
      end
      S_PUSH: instr_o = enc_sw(sreg_rn, cur_adj_i);
      S_POP:  instr_o = enc_lw(sreg_rn, cur_adj_i);
      S_RA: begin
        instr_o = is_load ? enc_lw(REG_RA, cur_adj_i) : enc_sw(REG_RA, cur_adj_i);
      end
      S_SP: instr_o = enc_addi(REG_SP, REG_SP, sp_imm);
      S_DMOVE: begin
        // Second move uses a1
        if (seq_kind_i == MVSA01) begin
          instr_o = enc_addi(mv_rn2, REG_A1, 12'h000);
        end else begin
          instr_o = enc_addi(REG_A1, mv_rn2, 12'h000);
        end
      end
      // a0 cleared for popretz
      S_A0:  instr_o = enc_addi(REG_A0, 5'd0, 12'h000);
      // jalr x0, 0(ra)
      S_RET: instr_o = {12'h000, REG_RA, 3'b000, 5'd0, OPCODE_JALR};
      default: instr_o = {16'h0000, instr_i};
    endcase
  end

endmodule

//--- zc_sequencer.sv
/*
 * Zcmp push/pop and double-move sequencer top level
 * Output path is combinational from instr_i, so the source holds the
 * word until ready_o, and RV32E limits the usable s-registers
 */

`timescale 1ns/1ps

module zc_sequencer import zc_pkg::*; #(
  parameter bit RV32E = 1'b0
) (
  input  logic        clk,
  input  logic        rst_n,
  // Fetch side
  input  cinstr_t     instr_i,
  input  logic        valid_i,
  input  logic        kill_i,
  output logic        ready_o,
  // Decode side
  input  logic        ready_i,
  output instr_word_t instr_o,
  output logic        valid_o,
  output logic        seq_first_o,
  output logic        seq_last_o
);

  seq_kind_e  seq_kind;
  logic       legal;
  seq_cnt_t   regs_saved;
  stack_adj_t total_adj;
  stack_adj_t cur_adj;
  seq_cnt_t   sreg_idx;
  seq_state_e state;
  seq_cnt_t   cnt;

  zc_decode #(
    .RV32E (RV32E)
  ) u_decode (
    .instr_i    (instr_i),
    .seq_kind_o (seq_kind),
    .legal_o    (legal)
  );

  // Register list in 7:4, extra stack units in 3:2
  zc_stack_calc u_stack_calc (
    .rlist_i      (instr_i[7:4]),
    .spimm_i      (instr_i[3:2]),
    .seq_kind_i   (seq_kind),
    .cnt_i        (cnt),
    .regs_saved_o (regs_saved),
    .total_adj_o  (total_adj),
    .cur_adj_o    (cur_adj),
    .sreg_idx_o   (sreg_idx)
  );

  zc_seq_fsm u_seq_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .ready_i      (ready_i),
    .kill_i       (kill_i),
    .legal_i      (legal),
    .seq_kind_i   (seq_kind),
    .regs_saved_i (regs_saved),
    .state_o      (state),
    .cnt_o        (cnt),
    .valid_o      (valid_o),
    .ready_o      (ready_o),
    .seq_first_o  (seq_first_o),
    .seq_last_o   (seq_last_o)
  );

  zc_instr_gen u_instr_gen (
    .instr_i      (instr_i),
    .state_i      (state),
    .seq_kind_i   (seq_kind),
    .regs_saved_i (regs_saved),
    .cur_adj_i    (cur_adj),
    .total_adj_i  (total_adj),
    .sreg_idx_i   (sreg_idx),
    .instr_o      (instr_o)
  );

endmodule

//--- zc_sequencer_asserts.sv
/*
 * Handshake and state checks bound into every zc_seq_fsm instance
 * All checks are disabled while reset is asserted
 */

`timescale 1ns/1ps

module zc_sequencer_asserts import zc_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       ready_i,
  input logic       kill_i,
  input logic       beat_valid_i,
  input logic       first_i,
  input logic       last_i,
  input seq_state_e state_i,
  input seq_cnt_t   cnt_i
);

  // A stalled beat keeps its place in the sequence
  stall_holds_beat: assert property (
    @(posedge clk) disable iff (!rst_n)
    beat_valid_i && !ready_i |=> $stable(state_i) && $stable(cnt_i)
  ) else $error("FSM advanced while the decode side stalled");

  // An accepted first beat moves the FSM out of S_IDLE
  first_leaves_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    first_i && ready_i |=> !first_i
  ) else $error("seq_first_o repeated after an accepted first beat");

  // The beat after an accepted last beat opens a new sequence
  last_returns_to_first: assert property (
    @(posedge clk) disable iff (!rst_n)
    last_i && ready_i ##1 beat_valid_i |-> first_i
  ) else $error("Beat after an accepted seq_last_o is not marked first");

  // Kill drops the sequence at the next edge
  kill_to_idle: assert property (
    @(posedge clk) disable iff (!rst_n) kill_i |=> state_i == S_IDLE
  ) else $error("FSM not idle one cycle after kill");

endmodule

bind zc_seq_fsm zc_sequencer_asserts u_asserts (
  .clk          (clk),
  .rst_n        (rst_n),
  .ready_i      (ready_i),
  .kill_i       (kill_i),
  .beat_valid_i (valid_o),
  .first_i      (seq_first_o),
  .last_i       (seq_last_o),
  .state_i      (state_o),
  .cnt_i        (cnt_o)
);

//--- tb_zc_sequencer.sv
/*
 * Testbench for zc_sequencer with RV32E off
 * Vectors are read from zc_sequencer_input.txt in the working directory
 * The run stops at the first mismatch
 */

`timescale 1ns/1ps

module tb_zc_sequencer import zc_pkg::*; ();

  localparam int CLK_HALF = 20;

  logic        clk;
  logic        rst_n;
  cinstr_t     instr_i;
  logic        valid_i;
  logic        kill_i;
  logic        ready_i;
  instr_word_t instr_o;
  logic        valid_o;
  logic        ready_o;
  logic        seq_first_o;
  logic        seq_last_o;

  // Vector table with the expected words of all tests stored back to back
  string       test_name[$];
  cinstr_t     test_word[$];
  int          test_kill[$];
  int          test_len[$];
  int          test_base[$];
  instr_word_t exp_words[$];

  integer seed;
  int     cycles;
  int     timeout_limit;

  zc_sequencer #(
    .RV32E (1'b0)
  ) uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_i     (instr_i),
    .valid_i     (valid_i),
    .kill_i      (kill_i),
    .ready_o     (ready_o),
    .ready_i     (ready_i),
    .instr_o     (instr_o),
    .valid_o     (valid_o),
    .seq_first_o (seq_first_o),
    .seq_last_o  (seq_last_o)
  );

  // 40 ns period
  always #CLK_HALF clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_word(input string test, input string what,
                            input instr_word_t expected, input instr_word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("Error: test %s, %s expected %h actual %h",
                          test, what, expected, actual));
    end
  endtask

  task automatic check_flag(input string test, input string what,
                            input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("Error: test %s, %s expected %b actual %b",
                          test, what, expected, actual));
    end
  endtask

  // Downstream ready about three cycles in four
  function automatic logic next_ready();
    integer r;
    r = $random(seed);
    return (r & 3) != 0;
  endfunction

  // Tokens are name, word, kill beat and word count, then the expected words
  task automatic load_vectors();
    int          fd;
    int          code;
    int          ch;
    string       name;
    cinstr_t     cword;
    int          kill_n;
    int          n;
    instr_word_t w;
    fd = $fopen("zc_sequencer_input.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the vector file zc_sequencer_input.txt");
    end
    while ($fscanf(fd, "%s", name) == 1) begin
      if (name.getc(0) == "#") begin
        // Comment runs to the end of the line
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else begin
        code = $fscanf(fd, "%h %d %d", cword, kill_n, n);
        if (code != 3 || (kill_n != 0 && kill_n != n)) begin
          abort_run($sformatf("Malformed vector line for test %s", name));
        end
        test_name.push_back(name);
        test_word.push_back(cword);
        test_kill.push_back(kill_n);
        test_len.push_back(n);
        test_base.push_back(exp_words.size());
        for (int i = 0; i < n; i++) begin
          code = $fscanf(fd, "%h", w);
          if (code != 1) begin
            abort_run($sformatf("Missing expected word for test %s", name));
          end
          exp_words.push_back(w);
        end
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // One compressed word from offer to consumption
  //////////////////////////////////////////////////////////////////////

  task automatic run_test(input int t);
    int    beat;
    int    len;
    int    kill_at;
    bit    done;
    bit    killing;
    logic  is_last;
    string name;
    beat    = 0;
    done    = 1'b0;
    killing = 1'b0;
    name    = test_name[t];
    len     = test_len[t];
    kill_at = test_kill[t];
    instr_i <= test_word[t];
    valid_i <= 1'b1;
    kill_i  <= 1'b0;
    ready_i <= next_ready();
    while (!done) begin
      @(negedge clk);
      if (killing || len == 0) begin
        // Nothing to send so the word is taken at once
        check_flag(name, "valid_o", 1'b0, valid_o);
        check_flag(name, "seq_first_o", 1'b0, seq_first_o);
        check_flag(name, "seq_last_o", 1'b0, seq_last_o);
        check_flag(name, "ready_o", 1'b1, ready_o);
        done = 1'b1;
      end else if (!valid_o) begin
        abort_run($sformatf("Test %s lost valid_o before beat %0d", name, beat));
      end else begin
        is_last = (kill_at == 0) && (beat == len - 1);
        check_word(name, $sformatf("instr_o beat %0d", beat),
                   exp_words[test_base[t] + beat], instr_o);
        check_flag(name, "seq_first_o", beat == 0, seq_first_o);
        check_flag(name, "seq_last_o", is_last, seq_last_o);
        // Fetch side only released with the accepted last beat
        check_flag(name, "ready_o", is_last && ready_i, ready_o);
        if (ready_i) begin
          beat++;
          done = is_last;
        end
      end
      @(posedge clk);
      if (!done) begin
        if (kill_at != 0 && beat == kill_at) begin
          kill_i  <= 1'b1;
          killing = 1'b1;
        end
        ready_i <= next_ready();
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Timeout and main sequence
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (timeout_limit > 0 && cycles >= timeout_limit) begin
      abort_run($sformatf("Timeout: the tests did not finish within %0d cycles", cycles));
    end
  end

  initial begin
    seed          = 32'hf64f9400;
    clk           = 1'b0;
    rst_n         = 1'b0;
    instr_i       = '0;
    valid_i       = 1'b0;
    kill_i        = 1'b0;
    ready_i       = 1'b0;
    cycles        = 0;
    timeout_limit = 0;
    load_vectors();
    timeout_limit = exp_words.size() * 4 + 200;
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_flag("reset", "valid_o", 1'b0, valid_o);
    check_flag("reset", "ready_o", 1'b1, ready_o);
    @(posedge clk);
    rst_n <= 1'b1;
    for (int t = 0; t < test_name.size(); t++) begin
      run_test(t);
    end
    valid_i <= 1'b0;
    kill_i  <= 1'b0;
    @(negedge clk);
    check_flag("idle_after_run", "valid_o", 1'b0, valid_o);
    check_flag("idle_after_run", "ready_o", 1'b1, ready_o);
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- zc_sequencer_input.txt
# name  cinstr  kill_after  nwords  then nwords expected 32-bit words in hex
# kill_after 0 runs the word to its end, else kill follows that many beats
push_r4_i0       B842 0 2  FE112E23 FF010113
push_r5_i1       B856 0 3  FE812E23 FE112C23 FE010113
push_r14_i2      B8EA 0 12 FF912E23 FF812C23 FF712A23 FF612823 FF512623 FF412423
                           FF312223 FF212023 FC912E23 FC812C23 FC112A23 FB010113
push_r15_i3      B8FE 0 14 FFB12E23 FFA12C23 FF912A23 FF812823 FF712623 FF612423
                           FF512223 FF412023 FD312E23 FD212C23 FC912A23 FC812823
                           FC112623 F9010113
pop_r6_i0        BA62 0 4  00C12483 00812403 00412083 01010113
popret_r5_i1     BE56 0 4  01C12403 01812083 02010113 00008067
popretz_r7_i0    BC72 0 7  00C12903 00812483 00412403 00012083 01010113 00000513
                           00008067
popret_r4_i2     BE4A 0 3  02C12083 03010113 00008067
mva01s_s0_s1     AC66 0 2  00040513 00048593
mvsa01_s2_s7     AD3E 0 2  00050913 00058B93
bad_rlist3       B832 0 0
bad_equal_move   ACE6 0 0
other_quadrant   0001 0 0
kill_push_r15    B8F2 3 3  FFB12E23 FFA12C23 FF912A23
kill_pop_r6      BA62 1 1  00C12483
push_after_kill  B856 0 3  FE812E23 FE112C23 FE010113

//--- zc_sequencer.f
zc_pkg.sv
zc_decode.sv
zc_stack_calc.sv
zc_seq_fsm.sv
zc_instr_gen.sv
zc_sequencer.sv
zc_sequencer_asserts.sv
tb_zc_sequencer.sv
